//--- dv/audio_mixer_tests.svh
// Mixer reference model and directed tests

//////////////////////
// Reference model
//////////////////////

// Code 0 mutes and others divide by a power of two rounding down
function automatic int volume_scale(int value, vol_t code);
	if (code == 0) begin
		return 0;
	end
	return value >>> (15 - code[4:1]);
endfunction

function automatic int soft_compress(int value, boost_t b);
	int knee;
	int slope;
	int fall;
	int base;
	int mag;
	int curve;
	knee  = (b == 2'd1) ? COMP_X1 : COMP_X2;
	slope = (b == 2'd1) ? COMP_A1 : COMP_A2;
	fall  = (b == 2'd1) ? COMP_F1 : COMP_F2;
	base  = (b == 2'd1) ? COMP_B1 : COMP_B2;
	mag   = (value < 0) ? -value : value;
	curve = (mag < knee) ? mag * slope : (mag - knee) / fall + base;
	curve = curve & 'hFFFF;
	return (value < 0) ? -curve : curve;
endfunction

// One output channel (ch 1 is right) from the current register contents
function automatic sample_t model_output(wide_sample_t sb, logic spk, sample_t midi,
	sample_t cd, int ch);
	int          sh;
	logic [15:0] ctrl;
	vol_t        code;
	int          spk_word;
	int          sum;
	sample_t     mix;
	sh       = (ch == 1) ? 8 : 0;
	ctrl     = shadow[REG_CTRL];
	spk_word = spk ? (1 << (11 + ctrl[3:2])) >> (3 - ctrl[1:0]) : 0;
	code     = shadow[REG_MIDI][sh +: 5];
	if (ctrl[7]) begin
		code = ctrl[8] ? shadow[REG_LINE][sh +: 5] : 5'd0;
	end
	sum = int'(sb) + spk_word + (ctrl[9] ? 0 : volume_scale(midi, code));
	sum = (sum + (ctrl[6] ? int'(cd) : 0)) & 'h1FFFF;
	if (sum[16] != sum[15]) begin
		mix = sum[16] ? 16'sh8000 : 16'sh7FFF;
	end else begin
		mix = sample_t'(sum);
	end
	if (ctrl[5:4] != 2'd0) begin
		mix = sample_t'(soft_compress(mix, ctrl[5:4]));
	end
	return sample_t'(volume_scale(mix, shadow[REG_MASTER][sh +: 5]));
endfunction

task automatic send_modeled(wide_sample_t sbl, wide_sample_t sbr, logic spk,
	sample_t ml, sample_t mr, sample_t cl, sample_t cr);
	send_sample(sbl, sbr, spk, ml, mr, cl, cr,
		model_output(sbl, spk, ml, cl, 0), model_output(sbr, spk, mr, cr, 1));
endtask

// Quarter scale keeps most sums out of saturation
function automatic sample_t random_sample();
	return sample_t'($random(seed)) >>> 2;
endfunction

function automatic wide_sample_t random_wide();
	sample_t s;
	s = random_sample();
	return {s[SAMPLE_W-1], s};
endfunction

//////////////////////
// Directed tests
//////////////////////

task automatic test_reset_mute();
	test_name = "reset_mute";
	if (out_valid !== 1'b0 || wb_ack !== 1'b0) begin
		end_with_failure("Output strobe or bus acknowledge high after reset");
	end
	send_sample(17'h04000, 17'h1C000, 1'b1, 16'sd9000, -16'sd9000, 16'sd1234, -16'sd4321,
		16'sd0, 16'sd0);
	drain_pipeline();
endtask

task automatic test_register_access();
	logic [15:0] wr [4];
	logic [15:0] rd;
	test_name = "register_access";
	wr = '{16'h150A, 16'h0C1B, 16'h1F03, 16'h02B7};
	for (int a = 0; a < 4; a++) begin
		write_reg(2'(a), wr[a]);
	end
	for (int a = 0; a < 4; a++) begin
		read_reg(2'(a), rd);
		compare_reg($sformatf("register %0d", a), wr[a], rd);
	end
	// Bits outside the fields read back as zero
	write_reg(REG_CTRL, 16'hFFFF);
	read_reg(REG_CTRL, rd);
	compare_reg("control mask", 16'h03FF, rd);
	for (int a = 0; a < 4; a++) begin
		write_reg(2'(a), 16'h0000);
	end
endtask

task automatic test_source_mixing();
	logic [15:0] ctrl;
	test_name = "source_mixing";
	for (int k = 0; k < 8; k++) begin
		write_reg(REG_MASTER, {3'b000, 5'(20 + k), 3'b000, 5'(31 - k)});
		write_reg(REG_MIDI, 16'($random(seed)) & 16'h1F1F);
		write_reg(REG_LINE, 16'($random(seed)) & 16'h1F1F);
		// Boost off, MIDI mute on the last pass
		ctrl = {6'b000000, (k == 7), k[2], k[1], k[0], 2'b00, 2'(k), 2'(k + 1)};
		write_reg(REG_CTRL, ctrl);
		for (int n = 0; n < 12; n++) begin
			send_modeled(random_wide(), random_wide(), 1'($random(seed)),
				random_sample(), random_sample(), random_sample(), random_sample());
		end
		drain_pipeline();
	end
endtask

task automatic test_clamping();
	test_name = "clamping";
	write_reg(REG_MASTER, 16'h1F1F);
	write_reg(REG_MIDI, 16'h1F1F);
	write_reg(REG_LINE, 16'h0000);
	write_reg(REG_CTRL, 16'h0040);
	send_sample(17'h04E20, 17'h1B1E0, 1'b0, 16'sd20000, -16'sd20000, 16'sd20000,
		-16'sd20000, 16'sd32767, -16'sd32768);
	// Exactly full scale, then one past it
	send_sample(17'h04E20, 17'h1B1E0, 1'b0, 16'sd12767, -16'sd12768, 16'sd0, 16'sd0,
		16'sd32767, -16'sd32768);
	send_sample(17'h04E20, 17'h1B1E0, 1'b0, 16'sd12768, -16'sd12769, 16'sd0, 16'sd0,
		16'sd32767, -16'sd32768);
	send_sample(17'h07530, 17'h18AD0, 1'b0, 16'sd30000, 16'sd30000, -16'sd30000,
		-16'sd30000, 16'sd30000, -16'sd30000);
	drain_pipeline();
endtask

task automatic test_compressor();
	int      pts [10];
	int      knee;
	sample_t v;
	test_name = "compressor";
	write_reg(REG_MASTER, 16'h1F1F);
	write_reg(REG_MIDI, 16'h0000);
	for (int b = 1; b <= 3; b++) begin
		write_reg(REG_CTRL, {10'b0, 2'(b), 4'b0000} | 16'h0040);
		knee = (b == 1) ? COMP_X1 : COMP_X2;
		pts  = '{0, 1, knee - 1, knee, knee + 1, 20000, 32767, -1, -knee, -32768};
		for (int i = 0; i < 10; i++) begin
			v = sample_t'(pts[i]);
			send_modeled(17'd0, 17'd0, 1'b0, 16'sd0, 16'sd0, v, -v);
		end
		drain_pipeline();
	end
endtask

//--- dv/audio_mixer_tb.sv
// Audio mixer testbench
`timescale 1ns/10ps

module audio_mixer_tb
	import mix_pkg::*;
();

	localparam int NUM_TESTS      = 5;
	localparam int TIMEOUT_CYCLES = NUM_TESTS * 400;

	logic         clk_sys = 1'b0;
	logic         reset;
	logic         in_valid;
	wide_sample_t sb_l;
	wide_sample_t sb_r;
	logic         speaker;
	sample_t      midi_l;
	sample_t      midi_r;
	sample_t      cd_l;
	sample_t      cd_r;
	logic         wb_cyc;
	logic         wb_stb;
	logic         wb_we;
	logic [1:0]   wb_adr;
	logic [15:0]  wb_dat_w;
	logic [15:0]  wb_dat_r;
	logic         wb_ack;
	logic         out_valid;
	sample_t      audio_l;
	sample_t      audio_r;

	int           cycle_count = 0;
	int           seed        = 43;
	string        test_name   = "reset";

	// Register contents as last written by the host
	logic [15:0]  shadow [4];

	// Expected samples and the cycle their input went in
	sample_t      exp_l [$];
	sample_t      exp_r [$];
	int           exp_cycle [$];

	audio_mixer_top #(.SAMPLE_W(SAMPLE_W)) i_audio_mixer_top (.*);

	always #10 clk_sys = ~clk_sys;

	always @(posedge clk_sys) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= TIMEOUT_CYCLES) begin
			end_with_failure($sformatf("Run timed out after %0d cycles in test %s",
				cycle_count, test_name));
		end
	end

	task automatic end_with_failure(string why);
		$display("%s", why);
		$display("TEST FAILED");
		$fatal(1, "Simulation stopped on error");
	endtask

	//////////////////////
	// Compare tasks
	//////////////////////

	task automatic compare_sample(string what, sample_t expected, sample_t actual);
		if (actual !== expected) begin
			end_with_failure($sformatf("FAILED %s %s: expected %0d, actual %0d",
				test_name, what, expected, actual));
		end
	endtask

	task automatic compare_reg(string what, logic [15:0] expected, logic [15:0] actual);
		if (actual !== expected) begin
			end_with_failure($sformatf("FAILED %s %s: expected 0x%04h, actual 0x%04h",
				test_name, what, expected, actual));
		end
	endtask

	task automatic next_negedge();
		@(negedge clk_sys);
	endtask

	//////////////////////
	// Wishbone host
	//////////////////////

	task automatic bus_access(logic write, logic [1:0] addr, logic [15:0] data,
		output logic [15:0] rdata);
		int waits;
		waits = 0;
		next_negedge();
		wb_cyc   = 1'b1;
		wb_stb   = 1'b1;
		wb_we    = write;
		wb_adr   = addr;
		wb_dat_w = data;
		do begin
			next_negedge();
			waits++;
		end while (!wb_ack && waits < 8);
		if (!wb_ack) begin
			end_with_failure($sformatf("No bus acknowledge in test %s", test_name));
		end
		if (waits != 1) begin
			end_with_failure($sformatf("Bus acknowledge came %0d cycles after the request",
				waits));
		end
		rdata  = wb_dat_r;
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we  = 1'b0;
	endtask

	task automatic write_reg(logic [1:0] addr, logic [15:0] data);
		logic [15:0] unused;
		bus_access(1'b1, addr, data, unused);
		shadow[addr] = data;
	endtask

	task automatic read_reg(logic [1:0] addr, output logic [15:0] data);
		bus_access(1'b0, addr, '0, data);
	endtask

	//////////////////////
	// Sample stream
	//////////////////////

	// Takes one output sample per strobe and checks value and latency
	task automatic check_output();
		int latency;
		if (out_valid) begin
			if (exp_l.size() == 0) begin
				end_with_failure($sformatf("Output strobe without an input sample in test %s",
					test_name));
			end
			latency = cycle_count - exp_cycle.pop_front();
			if (latency != PIPE_LATENCY) begin
				end_with_failure($sformatf("Output came %0d cycles after its input in test %s",
					latency, test_name));
			end
			compare_sample("left", exp_l.pop_front(), audio_l);
			compare_sample("right", exp_r.pop_front(), audio_r);
		end
	endtask

	task automatic send_sample(wide_sample_t sbl, wide_sample_t sbr, logic spk,
		sample_t ml, sample_t mr, sample_t cl, sample_t cr, sample_t el, sample_t er);
		next_negedge();
		check_output();
		in_valid = 1'b1;
		sb_l     = sbl;
		sb_r     = sbr;
		speaker  = spk;
		midi_l   = ml;
		midi_r   = mr;
		cd_l     = cl;
		cd_r     = cr;
		exp_l.push_back(el);
		exp_r.push_back(er);
		exp_cycle.push_back(cycle_count);
	endtask

	task automatic drain_pipeline();
		for (int i = 0; i < PIPE_LATENCY + 2; i++) begin
			next_negedge();
			check_output();
			in_valid = 1'b0;
		end
		if (exp_l.size() != 0) begin
			end_with_failure($sformatf("%0d output samples missing in test %s",
				exp_l.size(), test_name));
		end
	endtask

	`include "audio_mixer_tests.svh"

	initial begin
		reset    = 1'b1;
		in_valid = 1'b0;
		sb_l     = '0;
		sb_r     = '0;
		speaker  = 1'b0;
		midi_l   = '0;
		midi_r   = '0;
		cd_l     = '0;
		cd_r     = '0;
		wb_cyc   = 1'b0;
		wb_stb   = 1'b0;
		wb_we    = 1'b0;
		wb_adr   = '0;
		wb_dat_w = '0;
		for (int a = 0; a < 4; a++) begin
			shadow[a] = '0;
		end
		repeat (2) @(posedge clk_sys);
		@(negedge clk_sys);
		reset = 1'b0;

		test_reset_mute();
		test_register_access();
		test_source_mixing();
		test_clamping();
		test_compressor();

		$display("TEST OK");
		$finish;
	end

endmodule

//--- files.f
+incdir+dv
hw/mix_pkg.sv
hw/mix_regs.sv
hw/mix_source_scale.sv
hw/mix_sum_clamp.sv
hw/mix_compressor.sv
hw/mix_master_volume.sv
hw/audio_mixer_top.sv
dv/audio_mixer_tb.sv

//--- hw/audio_mixer_top.sv
// Audio output mixer
`timescale 1ns/10ps

module audio_mixer_top
	import mix_pkg::*;
#(
	parameter int SAMPLE_W = mix_pkg::SAMPLE_W
)
(
	input  logic         clk_sys,
	input  logic         reset,

	input  logic         in_valid,
	input  wide_sample_t sb_l,
	input  wide_sample_t sb_r,
	input  logic         speaker,
	input  sample_t      midi_l,
	input  sample_t      midi_r,
	input  sample_t      cd_l,
	input  sample_t      cd_r,

	input  logic         wb_cyc,
	input  logic         wb_stb,
	input  logic         wb_we,
	input  logic [1:0]   wb_adr,
	input  logic [15:0]  wb_dat_w,
	output logic [15:0]  wb_dat_r,
	output logic         wb_ack,

	output logic         out_valid,
	output sample_t      audio_l,
	output sample_t      audio_r
);

	vol_t         vol_l, vol_r;
	vol_t         midi_vol_l, midi_vol_r;
	vol_t         line_vol_l, line_vol_r;
	spk_vol_t     spk_vol;
	logic [1:0]   spk_boost;
	boost_t       boost;
	logic         cd_en, line_in_sel, line_en, midi_mute;

	logic         s1_valid, s2_valid, s3_valid;
	wide_sample_t s1_sb_l, s1_sb_r, s1_spk;
	sample_t      s1_midi_l, s1_midi_r, s1_cd_l, s1_cd_r;
	sample_t      mix_l, mix_r;
	sample_t      comp_l, comp_r, raw_l, raw_r;

	mix_regs i_mix_regs (
		.clk_sys, .reset,
		.wb_cyc, .wb_stb, .wb_we, .wb_adr, .wb_dat_w, .wb_dat_r, .wb_ack,
		.vol_l, .vol_r, .midi_vol_l, .midi_vol_r, .line_vol_l, .line_vol_r,
		.spk_vol, .spk_boost, .boost, .cd_en, .line_in_sel, .line_en, .midi_mute
	);

	//////////////////////
	// Sample pipeline
	//////////////////////

	mix_source_scale #(.SAMPLE_W(SAMPLE_W)) i_mix_source_scale (
		.clk_sys, .reset,
		.in_valid, .sb_l, .sb_r, .speaker, .midi_l, .midi_r, .cd_l, .cd_r,
		.midi_vol_l, .midi_vol_r, .line_vol_l, .line_vol_r, .line_in_sel, .line_en,
		.spk_vol, .spk_boost, .cd_en, .midi_mute,
		.s1_valid, .sb_l_o(s1_sb_l), .sb_r_o(s1_sb_r), .spk_o(s1_spk),
		.midi_l_o(s1_midi_l), .midi_r_o(s1_midi_r), .cd_l_o(s1_cd_l), .cd_r_o(s1_cd_r)
	);

	mix_sum_clamp #(.SAMPLE_W(SAMPLE_W)) i_mix_sum_clamp (
		.clk_sys, .reset,
		.s1_valid, .sb_l(s1_sb_l), .sb_r(s1_sb_r), .spk(s1_spk),
		.midi_l(s1_midi_l), .midi_r(s1_midi_r), .cd_l(s1_cd_l), .cd_r(s1_cd_r),
		.s2_valid, .mix_l, .mix_r
	);

	mix_compressor #(.SAMPLE_W(SAMPLE_W)) i_mix_compressor (
		.clk_sys, .reset,
		.s2_valid, .mix_l, .mix_r, .boost,
		.s3_valid, .comp_l, .comp_r, .raw_l, .raw_r
	);

	mix_master_volume i_mix_master_volume (
		.clk_sys, .reset,
		.s3_valid, .comp_l, .comp_r, .raw_l, .raw_r, .boost, .vol_l, .vol_r,
		.out_valid, .audio_l, .audio_r
	);

endmodule

//--- hw/mix_compressor.sv
// Audio boost soft compressor
`timescale 1ns/10ps

module mix_compressor
	import mix_pkg::*;
#(
	parameter int SAMPLE_W = mix_pkg::SAMPLE_W
)
(
	input  logic    clk_sys,
	input  logic    reset,

	input  logic    s2_valid,
	input  sample_t mix_l,
	input  sample_t mix_r,
	input  boost_t  boost,

	output logic    s3_valid,
	output sample_t comp_l,
	output sample_t comp_r,
	output sample_t raw_l,
	output sample_t raw_r
);

	sample_t    mix_in [2];
	logic [3:0] valid_pipe;

	assign mix_in[0] = mix_l;
	assign mix_in[1] = mix_r;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			valid_pipe <= '0;
		end else begin
			valid_pipe <= {valid_pipe[2:0], s2_valid};
		end
	end

	assign s3_valid = valid_pipe[3];

	for (genvar ch = 0; ch < 2; ch++) begin : g_chan
		logic [SAMPLE_W-1:0] mag;
		logic [SAMPLE_W-1:0] curve1;
		logic [SAMPLE_W-1:0] curve2;
		logic [SAMPLE_W-1:0] sel;
		logic                sign1;
		logic                sign2;
		logic                sign3;
		sample_t             raw1;
		sample_t             raw2;
		sample_t             raw3;
		sample_t             comp_q;
		sample_t             raw_q;

		always_ff @(posedge clk_sys) begin
			// Magnitude where -32768 maps to 32768 unsigned
			mag   <= mix_in[ch][SAMPLE_W-1] ? -mix_in[ch] : mix_in[ch];
			sign1 <= mix_in[ch][SAMPLE_W-1];
			raw1  <= mix_in[ch];

			// Both curves in parallel
			curve1 <= (mag < COMP_X1) ? SAMPLE_W'(mag * COMP_A1) :
				SAMPLE_W'((mag - COMP_X1) / COMP_F1 + COMP_B1);
			curve2 <= (mag < COMP_X2) ? SAMPLE_W'(mag * COMP_A2) :
				SAMPLE_W'((mag - COMP_X2) / COMP_F2 + COMP_B2);
			sign2  <= sign1;
			raw2   <= raw1;

			// 4x curve for boost 2 and 3
			sel   <= boost[1] ? curve2 : curve1;
			sign3 <= sign2;
			raw3  <= raw2;

			comp_q <= sign3 ? -sel : sel;
			raw_q  <= raw3;
		end
	end

	assign comp_l = g_chan[0].comp_q;
	assign comp_r = g_chan[1].comp_q;
	assign raw_l  = g_chan[0].raw_q;
	assign raw_r  = g_chan[1].raw_q;

endmodule

//--- hw/mix_master_volume.sv
// Master volume output stage
`timescale 1ns/10ps

module mix_master_volume
	import mix_pkg::*;
(
	input  logic    clk_sys,
	input  logic    reset,

	input  logic    s3_valid,
	input  sample_t comp_l,
	input  sample_t comp_r,
	input  sample_t raw_l,
	input  sample_t raw_r,
	input  boost_t  boost,
	input  vol_t    vol_l,
	input  vol_t    vol_r,

	output logic    out_valid,
	output sample_t audio_l,
	output sample_t audio_r
);

	// Cycles since reset, one bit per pipeline stage
	logic [PIPE_LATENCY-1:0] reset_hist;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			out_valid  <= 1'b0;
			reset_hist <= '1;
		end else begin
			out_valid  <= s3_valid;
			reset_hist <= reset_hist << 1;
		end
	end

	always_ff @(posedge clk_sys) begin
		audio_l <= apply_volume((boost != '0) ? comp_l : raw_l, vol_l);
		audio_r <= apply_volume((boost != '0) ? comp_r : raw_r, vol_r);
	end

	// A sample needs the full pipeline depth to reach the output
	a_min_latency: assert property (@(posedge clk_sys) disable iff (reset)
		(|reset_hist) |-> !out_valid);

endmodule

//--- hw/mix_pkg.sv
// Audio mixer shared definitions

package mix_pkg;

	//////////////////////
	// Sample types
	//////////////////////

	parameter int SAMPLE_W = 16;

	typedef logic signed [SAMPLE_W-1:0] sample_t;
	// Sum word that also carries the Sound Blaster input
	typedef logic [SAMPLE_W:0]          wide_sample_t;
	typedef logic [4:0]                 vol_t;
	typedef logic [1:0]                 spk_vol_t;
	// 0 off, 1 is 2x, 2 and 3 are 4x
	typedef logic [1:0]                 boost_t;

	// Register word addresses
	localparam logic [1:0] REG_MASTER = 2'd0;
	localparam logic [1:0] REG_MIDI   = 2'd1;
	localparam logic [1:0] REG_LINE   = 2'd2;
	localparam logic [1:0] REG_CTRL   = 2'd3;

	//////////////////////
	// Compressor curves
	//////////////////////

	localparam int COMP_F1 = 4;
	localparam int COMP_A1 = 2;
	localparam int COMP_F2 = 8;
	localparam int COMP_A2 = 4;

	// Knee points where both slopes reach full scale together
	localparam int COMP_X1 = ((2**(SAMPLE_W-1) - 1) * (COMP_F1 - 1)) / (COMP_F1 * COMP_A1 - 1);
	localparam int COMP_B1 = COMP_X1 * COMP_A1;
	localparam int COMP_X2 = ((2**(SAMPLE_W-1) - 1) * (COMP_F2 - 1)) / (COMP_F2 * COMP_A2 - 1);
	localparam int COMP_B2 = COMP_X2 * COMP_A2;

	// Input strobe to output strobe, in clock cycles
	localparam int PIPE_LATENCY = 7;

	// Code 0 mutes and others shift right by 15 minus the upper four bits
	function automatic sample_t apply_volume(sample_t smp, vol_t vol);
		logic [3:0] shift;
		shift = ~vol[4:1];
		if (vol == '0) begin
			return '0;
		end
		return smp >>> shift;
	endfunction

endpackage

//--- hw/mix_regs.sv
// Mixer control registers
`timescale 1ns/10ps

module mix_regs
	import mix_pkg::*;
(
	input  logic        clk_sys,
	input  logic        reset,

	input  logic        wb_cyc,
	input  logic        wb_stb,
	input  logic        wb_we,
	input  logic [1:0]  wb_adr,
	input  logic [15:0] wb_dat_w,
	output logic [15:0] wb_dat_r,
	output logic        wb_ack,

	output vol_t        vol_l,
	output vol_t        vol_r,
	output vol_t        midi_vol_l,
	output vol_t        midi_vol_r,
	output vol_t        line_vol_l,
	output vol_t        line_vol_r,
	output spk_vol_t    spk_vol,
	output logic [1:0]  spk_boost,
	output boost_t      boost,
	output logic        cd_en,
	output logic        line_in_sel,
	output logic        line_en,
	output logic        midi_mute
);

	// New request, not yet acknowledged
	logic access;

	assign access = wb_cyc && wb_stb && !wb_ack;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			wb_ack      <= 1'b0;
			vol_l       <= '0;
			vol_r       <= '0;
			midi_vol_l  <= '0;
			midi_vol_r  <= '0;
			line_vol_l  <= '0;
			line_vol_r  <= '0;
			spk_vol     <= '0;
			spk_boost   <= '0;
			boost       <= '0;
			cd_en       <= 1'b0;
			line_in_sel <= 1'b0;
			line_en     <= 1'b0;
			midi_mute   <= 1'b0;
		end else begin
			wb_ack <= access;
			if (access && wb_we) begin
				case (wb_adr)
					REG_MASTER: begin
						vol_l <= wb_dat_w[4:0];
						vol_r <= wb_dat_w[12:8];
					end
					REG_MIDI: begin
						midi_vol_l <= wb_dat_w[4:0];
						midi_vol_r <= wb_dat_w[12:8];
					end
					REG_LINE: begin
						line_vol_l <= wb_dat_w[4:0];
						line_vol_r <= wb_dat_w[12:8];
					end
					REG_CTRL: begin
						spk_vol     <= wb_dat_w[1:0];
						spk_boost   <= wb_dat_w[3:2];
						boost       <= wb_dat_w[5:4];
						cd_en       <= wb_dat_w[6];
						line_in_sel <= wb_dat_w[7];
						line_en     <= wb_dat_w[8];
						midi_mute   <= wb_dat_w[9];
					end
				endcase
			end
		end
	end

	// Read data lines up with ack
	always_ff @(posedge clk_sys) begin
		if (access) begin
			case (wb_adr)
				REG_MASTER: wb_dat_r <= {3'b000, vol_r, 3'b000, vol_l};
				REG_MIDI:   wb_dat_r <= {3'b000, midi_vol_r, 3'b000, midi_vol_l};
				REG_LINE:   wb_dat_r <= {3'b000, line_vol_r, 3'b000, line_vol_l};
				REG_CTRL:   wb_dat_r <= {6'b000000, midi_mute, line_en, line_in_sel, cd_en,
					boost, spk_boost, spk_vol};
			endcase
		end
	end

	// Every ack answers a request held in the previous cycle
	a_ack_follows_req: assert property (@(posedge clk_sys) disable iff (reset)
		wb_ack |-> $past(wb_cyc && wb_stb && !wb_ack));

endmodule

//--- hw/mix_source_scale.sv
// Mixer source scaling stage
`timescale 1ns/10ps

module mix_source_scale
	import mix_pkg::*;
#(
	parameter int SAMPLE_W = mix_pkg::SAMPLE_W
)
(
	input  logic         clk_sys,
	input  logic         reset,

	input  logic         in_valid,
	input  wide_sample_t sb_l,
	input  wide_sample_t sb_r,
	input  logic         speaker,
	input  sample_t      midi_l,
	input  sample_t      midi_r,
	input  sample_t      cd_l,
	input  sample_t      cd_r,

	input  vol_t         midi_vol_l,
	input  vol_t         midi_vol_r,
	input  vol_t         line_vol_l,
	input  vol_t         line_vol_r,
	input  logic         line_in_sel,
	input  logic         line_en,
	input  spk_vol_t     spk_vol,
	input  logic [1:0]   spk_boost,
	input  logic         cd_en,
	input  logic         midi_mute,

	output logic         s1_valid,
	output wide_sample_t sb_l_o,
	output wide_sample_t sb_r_o,
	output wide_sample_t spk_o,
	output sample_t      midi_l_o,
	output sample_t      midi_r_o,
	output sample_t      cd_l_o,
	output sample_t      cd_r_o
);

	// Speaker base bit is 11 for a 16-bit output
	localparam int SPK_BASE = SAMPLE_W - 5;

	logic [SAMPLE_W:0] spk_placed;
	logic [SAMPLE_W:0] spk_word;
	vol_t              midi_code_l;
	vol_t              midi_code_r;

	//////////////////////
	// Speaker
	//////////////////////

	assign spk_placed = {{SAMPLE_W{1'b0}}, speaker} << (SPK_BASE + int'(spk_boost));
	assign spk_word   = spk_placed >> (2'd3 - spk_vol);

	// Line volume replaces MIDI volume when line-in is selected
	assign midi_code_l = line_in_sel ? (line_en ? line_vol_l : '0) : midi_vol_l;
	assign midi_code_r = line_in_sel ? (line_en ? line_vol_r : '0) : midi_vol_r;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			s1_valid <= 1'b0;
		end else begin
			s1_valid <= in_valid;
		end
	end

	always_ff @(posedge clk_sys) begin
		sb_l_o   <= sb_l;
		sb_r_o   <= sb_r;
		spk_o    <= spk_word;
		midi_l_o <= midi_mute ? '0 : apply_volume(midi_l, midi_code_l);
		midi_r_o <= midi_mute ? '0 : apply_volume(midi_r, midi_code_r);
		cd_l_o   <= cd_en ? cd_l : '0;
		cd_r_o   <= cd_en ? cd_r : '0;
	end

endmodule

//--- hw/mix_sum_clamp.sv
// Mixer sum and saturation stage
`timescale 1ns/10ps

module mix_sum_clamp
	import mix_pkg::*;
#(
	parameter int SAMPLE_W = mix_pkg::SAMPLE_W
)
(
	input  logic         clk_sys,
	input  logic         reset,

	input  logic         s1_valid,
	input  wide_sample_t sb_l,
	input  wide_sample_t sb_r,
	input  wide_sample_t spk,
	input  sample_t      midi_l,
	input  sample_t      midi_r,
	input  sample_t      cd_l,
	input  sample_t      cd_r,

	output logic         s2_valid,
	output sample_t      mix_l,
	output sample_t      mix_r
);

	// Sum in one extra bit, then saturate on overflow
	function automatic sample_t sum_clamp(wide_sample_t sb, wide_sample_t spk_w,
		sample_t midi, sample_t cd);
		logic [SAMPLE_W:0] sum;
		sum = sb + spk_w + {midi[SAMPLE_W-1], midi} + {cd[SAMPLE_W-1], cd};
		if (sum[SAMPLE_W] != sum[SAMPLE_W-1]) begin
			return {sum[SAMPLE_W], {(SAMPLE_W-1){~sum[SAMPLE_W]}}};
		end
		return sum[SAMPLE_W-1:0];
	endfunction

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			s2_valid <= 1'b0;
		end else begin
			s2_valid <= s1_valid;
		end
	end

	always_ff @(posedge clk_sys) begin
		mix_l <= sum_clamp(sb_l, spk, midi_l, cd_l);
		mix_r <= sum_clamp(sb_r, spk, midi_r, cd_r);
	end

endmodule

//--- run_sim.sh
#!/bin/sh
# Build and run the audio mixer testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/10ps \
	--top-module audio_mixer_tb -Mdir obj_dir -f files.f
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/Vaudio_mixer_tb
status=$?
if [ $status -ne 0 ]; then
	echo "Simulation failed with status $status"
	exit $status
fi

exit 0
